//--- Bender.yml
package:
  name: dds_scope

sources:
  - src/dds_scope_pkg.sv
  - src/sample_if.sv
  - src/key_event_decoder.sv
  - src/dds_core.sv
  - src/sample_stream_out.sv
  - src/dds_scope_top.sv
  - target: test
    files:
      - testbench/clk_gen.sv
      - testbench/tb_dds_scope.sv

//--- src/dds_core.sv
`timescale 1ns/10ps

module dds_core #(
   parameter logic [dds_scope_pkg::PHASE_W-1:0] BASE_INC = 32'h0100_0000
) (
   input  logic                              CLK_25MHZ,
   input  logic                              reset_from_key,
   input  logic [3:0]                        tone_step,
   input  dds_scope_pkg::wave_sel_e          wave_sel,
   input  logic                              fsk_en,
   input  logic                              fsk_bit,
   input  logic [dds_scope_pkg::PHASE_W-1:0] fsk_inc,
   sample_if.src                             smp
);

   localparam int PW = dds_scope_pkg::PHASE_W;
   localparam int WW = dds_scope_pkg::WAVE_W;

   logic [PW-1:0] inc;
   logic [PW-1:0] phase_nxt;

   //////////////////////////////////////////////////
   // waveform shaping
   //////////////////////////////////////////////////

   function automatic logic signed [WW-1:0] shape(
      input logic [PW-1:0]            p,
      input dds_scope_pkg::wave_sel_e sel
   );
      logic [WW-1:0] t;
      logic [WW-1:0] u;
      t = p[PW-2 -: WW];           // bits just below the msb
      u = p[PW-1] ? ~t : t;        // fold second half back down
      case (sel)
         dds_scope_pkg::WAVE_SQUARE:
         begin
            if (p[PW-1])
               shape = {1'b1, {(WW-1){1'b0}}};   // most negative
            else
               shape = {1'b0, {(WW-1){1'b1}}};   // largest positive
         end
         dds_scope_pkg::WAVE_TRIANGLE:
            shape = {~u[WW-1], u[WW-2:0]};
         default:                                // saw
            shape = {~p[PW-1], p[PW-2 -: WW-1]};
      endcase
   endfunction

   //////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////

   // fsk bit picks the external step
   always_comb
   begin
      if (fsk_en && fsk_bit)
         inc = fsk_inc;
      else
         inc = PW'(tone_step) * BASE_INC;
   end

   assign phase_nxt = smp.phase + inc;

   // phase and wave registered as one pair
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         smp.valid <= 1'b0;
         smp.phase <= '0;
         smp.wave  <= shape('0, dds_scope_pkg::WAVE_SAW);
         smp.sel   <= dds_scope_pkg::WAVE_SAW;
      end
      else
      begin
         smp.valid <= 1'b1;
         smp.phase <= phase_nxt;
         smp.wave  <= shape(phase_nxt, wave_sel);
         smp.sel   <= wave_sel;
      end
   end

endmodule

//--- src/dds_scope_pkg.sv
package dds_scope_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////

   localparam int PHASE_W = 32;   // phase accumulator
   localparam int WAVE_W  = 12;   // signed waveform sample

   //////////////////////////////////////////////////
   // ps/2 set-2 event codes
   //////////////////////////////////////////////////

   // break code is the make code with bit 7 set
   typedef enum logic [7:0] {
      SC_MAKE_1      = 8'h16,
      SC_MAKE_2      = 8'h1E,
      SC_MAKE_3      = 8'h26,
      SC_MAKE_4      = 8'h25,
      SC_MAKE_5      = 8'h2E,
      SC_MAKE_6      = 8'h36,
      SC_MAKE_7      = 8'h3D,
      SC_MAKE_8      = 8'h3E,
      SC_MAKE_N      = 8'h31,
      SC_MAKE_M      = 8'h3A,
      SC_MAKE_SPACE  = 8'h29,
      SC_BREAK_1     = 8'h96,
      SC_BREAK_2     = 8'h9E,
      SC_BREAK_3     = 8'hA6,
      SC_BREAK_4     = 8'hA5,
      SC_BREAK_5     = 8'hAE,
      SC_BREAK_6     = 8'hB6,
      SC_BREAK_7     = 8'hBD,
      SC_BREAK_8     = 8'hBE,
      SC_BREAK_N     = 8'hB1,
      SC_BREAK_M     = 8'hBA,
      SC_BREAK_SPACE = 8'hA9
   } key_event_e;

   //////////////////////////////////////////////////
   // waveform and sample types
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      WAVE_SAW      = 2'd0,
      WAVE_SQUARE   = 2'd1,
      WAVE_TRIANGLE = 2'd2
   } wave_sel_e;

   typedef struct packed {
      logic [7:0] digits;   // bit 0 is key 1
      logic       space;
   } held_keys_t;

   // 32 + 12 + 2 = 46 bits
   typedef struct packed {
      logic        [PHASE_W-1:0] phase;
      logic signed [WAVE_W-1:0]  wave;
      wave_sel_e                 sel;
   } sample_t;

endpackage

//--- src/dds_scope_top.sv
`timescale 1ns/10ps

module dds_scope_top #(
   parameter logic [dds_scope_pkg::PHASE_W-1:0] BASE_INC    = 32'h0100_0000,
   parameter int                                SAMPLE_DIV  = 16,
   parameter int                                MAX_CREDITS = 4
) (
   input  logic                              CLK_25MHZ,
   input  logic                              reset_from_key,
   input  logic                              key_event_valid,
   input  dds_scope_pkg::key_event_e         key_event,
   input  logic                              fsk_en,
   input  logic                              fsk_bit,
   input  logic [dds_scope_pkg::PHASE_W-1:0] fsk_inc,
   input  logic                              credit_return,
   output dds_scope_pkg::held_keys_t         held_keys,
   output dds_scope_pkg::wave_sel_e          wave_sel,
   output logic                              sample_valid,
   output dds_scope_pkg::sample_t            sample_out
);

   logic [3:0] tone_step;

   sample_if smp_bus ();   // synthesizer to stream output

   //////////////////////////////////////////////////
   // input side
   //////////////////////////////////////////////////

   key_event_decoder u_key_event_decoder (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .held_keys       (held_keys),
      .tone_step       (tone_step),
      .wave_sel        (wave_sel)
   );

   //////////////////////////////////////////////////
   // synthesis and output side
   //////////////////////////////////////////////////

   dds_core #(
      .BASE_INC (BASE_INC)
   ) u_dds_core (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .tone_step      (tone_step),
      .wave_sel       (wave_sel),
      .fsk_en         (fsk_en),
      .fsk_bit        (fsk_bit),
      .fsk_inc        (fsk_inc),
      .smp            (smp_bus.src)
   );

   sample_stream_out #(
      .SAMPLE_DIV  (SAMPLE_DIV),
      .MAX_CREDITS (MAX_CREDITS)
   ) u_sample_stream_out (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .smp            (smp_bus.dst),
      .pause          (held_keys.space),   // space freezes the divider
      .credit_return  (credit_return),
      .sample_valid   (sample_valid),
      .sample_out     (sample_out)
   );

endmodule

//--- src/key_event_decoder.sv
`timescale 1ns/10ps

module key_event_decoder (
   input  logic                      CLK_25MHZ,
   input  logic                      reset_from_key,
   input  logic                      key_event_valid,
   input  dds_scope_pkg::key_event_e key_event,
   output dds_scope_pkg::held_keys_t held_keys,
   output logic [3:0]                tone_step,
   output dds_scope_pkg::wave_sel_e  wave_sel
);

   dds_scope_pkg::held_keys_t held_nxt;
   dds_scope_pkg::wave_sel_e  sel_nxt;
   logic [3:0]                step_nxt;

   //////////////////////////////////////////////////
   // event decode
   //////////////////////////////////////////////////

   always_comb
   begin
      held_nxt = held_keys;
      sel_nxt  = wave_sel;
      if (key_event_valid)
      begin
         case (key_event)
            dds_scope_pkg::SC_MAKE_1:      held_nxt.digits[0] = 1'b1;
            dds_scope_pkg::SC_MAKE_2:      held_nxt.digits[1] = 1'b1;
            dds_scope_pkg::SC_MAKE_3:      held_nxt.digits[2] = 1'b1;
            dds_scope_pkg::SC_MAKE_4:      held_nxt.digits[3] = 1'b1;
            dds_scope_pkg::SC_MAKE_5:      held_nxt.digits[4] = 1'b1;
            dds_scope_pkg::SC_MAKE_6:      held_nxt.digits[5] = 1'b1;
            dds_scope_pkg::SC_MAKE_7:      held_nxt.digits[6] = 1'b1;
            dds_scope_pkg::SC_MAKE_8:      held_nxt.digits[7] = 1'b1;
            dds_scope_pkg::SC_BREAK_1:     held_nxt.digits[0] = 1'b0;
            dds_scope_pkg::SC_BREAK_2:     held_nxt.digits[1] = 1'b0;
            dds_scope_pkg::SC_BREAK_3:     held_nxt.digits[2] = 1'b0;
            dds_scope_pkg::SC_BREAK_4:     held_nxt.digits[3] = 1'b0;
            dds_scope_pkg::SC_BREAK_5:     held_nxt.digits[4] = 1'b0;
            dds_scope_pkg::SC_BREAK_6:     held_nxt.digits[5] = 1'b0;
            dds_scope_pkg::SC_BREAK_7:     held_nxt.digits[6] = 1'b0;
            dds_scope_pkg::SC_BREAK_8:     held_nxt.digits[7] = 1'b0;
            dds_scope_pkg::SC_MAKE_SPACE:  held_nxt.space = 1'b1;
            dds_scope_pkg::SC_BREAK_SPACE: held_nxt.space = 1'b0;
            dds_scope_pkg::SC_MAKE_M:      // next waveform, wraps
               sel_nxt = (wave_sel == dds_scope_pkg::WAVE_TRIANGLE) ?
                         dds_scope_pkg::WAVE_SAW :
                         dds_scope_pkg::wave_sel_e'(wave_sel + 2'd1);
            dds_scope_pkg::SC_MAKE_N:      // previous waveform, wraps
               sel_nxt = (wave_sel == dds_scope_pkg::WAVE_SAW) ?
                         dds_scope_pkg::WAVE_TRIANGLE :
                         dds_scope_pkg::wave_sel_e'(wave_sel - 2'd1);
            default: ;                     // n/m breaks do nothing
         endcase
      end
   end

   // highest digit held wins, 0 when none
   always_comb
   begin
      step_nxt = 4'd0;
      for (int i = 0; i < 8; i++)
      begin
         if (held_nxt.digits[i])
            step_nxt = 4'(i + 1);
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
         tone_step <= 4'd0;
         wave_sel  <= dds_scope_pkg::WAVE_SAW;
      end
      else
      begin
         held_keys <= held_nxt;
         tone_step <= step_nxt;
         wave_sel  <= sel_nxt;
      end
   end

endmodule

//--- src/sample_if.sv
`timescale 1ns/10ps

// synthesizer output as seen by the stream side
interface sample_if;

   logic                                    valid;   // high from first cycle after reset
   logic        [dds_scope_pkg::PHASE_W-1:0] phase;
   logic signed [dds_scope_pkg::WAVE_W-1:0]  wave;    // computed from phase above
   dds_scope_pkg::wave_sel_e                 sel;

   // dds core drives the sample
   modport src (
      output valid,
      output phase,
      output wave,
      output sel
   );

   // stream output picks it up on its own ticks
   modport dst (
      input valid,
      input phase,
      input wave,
      input sel
   );

endinterface

//--- src/sample_stream_out.sv
`timescale 1ns/10ps

module sample_stream_out #(
   parameter int SAMPLE_DIV  = 16,
   parameter int MAX_CREDITS = 4
) (
   input  logic                   CLK_25MHZ,
   input  logic                   reset_from_key,
   sample_if.dst                  smp,
   input  logic                   pause,
   input  logic                   credit_return,
   output logic                   sample_valid,
   output dds_scope_pkg::sample_t sample_out
);

   localparam int DW = $clog2(SAMPLE_DIV + 1);
   localparam int CW = $clog2(MAX_CREDITS + 1);

   logic [DW-1:0] div_cnt;
   logic [CW-1:0] credit_cnt;
   logic          tick;
   logic          pending;
   logic          emit;

   //////////////////////////////////////////////////
   // sample divider
   //////////////////////////////////////////////////

   assign tick = !pause && (div_cnt == DW'(SAMPLE_DIV - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         div_cnt <= '0;
      else if (tick)
         div_cnt <= '0;
      else if (!pause)                  // frozen while space held
         div_cnt <= div_cnt + 1'b1;
   end

   //////////////////////////////////////////////////
   // credits and pending tick
   //////////////////////////////////////////////////

   // one idle cycle between pulses at least
   assign emit = (tick || pending) && (credit_cnt != '0) && smp.valid && !sample_valid;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         pending    <= 1'b0;
         credit_cnt <= CW'(MAX_CREDITS);
      end
      else
      begin
         pending <= (tick || pending) && !emit;   // extra ticks merge here
         case ({emit, credit_return})
            2'b10: credit_cnt <= credit_cnt - 1'b1;
            2'b01:
            begin
               if (credit_cnt < CW'(MAX_CREDITS))
                  credit_cnt <= credit_cnt + 1'b1;
            end
            default: ;                               // none, or spend and return
         endcase
      end
   end

   // outgoing sample register
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sample_valid <= 1'b0;
         sample_out   <= '0;
      end
      else
      begin
         sample_valid <= emit;
         if (emit)
            sample_out <= '{phase: smp.phase, wave: smp.wave, sel: smp.sel};
      end
   end

endmodule

//--- tb.f
src/dds_scope_pkg.sv
src/sample_if.sv
src/key_event_decoder.sv
src/dds_core.sv
src/sample_stream_out.sv
src/dds_scope_top.sv
testbench/clk_gen.sv
testbench/tb_dds_scope.sv

//--- testbench/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
   parameter real PERIOD_NS    = 40.0,
   parameter int  RESET_CYCLES = 8
) (
   output logic CLK_25MHZ,
   output logic reset_from_key
);

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #(PERIOD_NS / 2.0) CLK_25MHZ = ~CLK_25MHZ;
   end

   // reset held high for the first few edges
   initial
   begin
      reset_from_key = 1'b1;
      repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
   end

endmodule

//--- testbench/dds_scope_stim.txt
# K <event> <held_keys> <wave_sel>   key event and expected state, all hex
# F <fsk_en> <fsk_bit> <fsk_inc>  hex | C <samples> <mode 0/1/2> | P <cycles>  decimal
C 6 0
K 16 002 0
C 6 0
K 26 00A 0
C 6 1
K 96 008 0
C 6 0
K 3E 108 0
C 6 2
K BE 008 0
K A6 000 0
K 3A 000 1
K 3A 000 2
K 3A 000 0
K 31 000 2
K BA 000 2
K 25 010 2
C 8 1
K 31 010 1
C 6 0
F 1 1 01234567
C 6 0
F 1 0 01234567
C 4 0
F 0 1 01234567
C 4 0
K 29 011 1
P 96
K A9 010 1
C 4 0
K 2E 030 1
K 36 070 1
K 3D 0F0 1
K 1E 0F4 1
C 6 1

//--- testbench/tb_dds_scope.sv
`timescale 1ns/10ps

module tb_dds_scope;

   localparam logic [31:0] BASE_INC    = 32'h0100_0000;
   localparam int          SAMPLE_DIV  = 16;
   localparam int          MAX_CREDITS = 4;
   localparam int          PW          = dds_scope_pkg::PHASE_W;
   localparam int          WW          = dds_scope_pkg::WAVE_W;

   logic                      CLK_25MHZ;
   logic                      reset_from_key;
   logic                      key_event_valid;
   dds_scope_pkg::key_event_e key_event;
   logic                      fsk_en;
   logic                      fsk_bit;
   logic [PW-1:0]             fsk_inc;
   logic                      credit_return;
   dds_scope_pkg::held_keys_t held_keys;
   dds_scope_pkg::wave_sel_e  wave_sel;
   logic                      sample_valid;
   dds_scope_pkg::sample_t    sample_out;

   dds_scope_pkg::held_keys_t held_exp = '0;
   dds_scope_pkg::wave_sel_e  sel_exp  = dds_scope_pkg::WAVE_SAW;
   int                        seen      = 0;       // samples observed
   int                        given     = 0;       // credits handed back
   int                        cycle     = 0;
   int                        last_emit = -1000;
   int                        prev_emit = -1000;
   int unsigned               lcg_state = 66;

   clk_gen #(.PERIOD_NS(40.0), .RESET_CYCLES(8)) u_clk_gen (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key)
   );

   dds_scope_top #(
      .BASE_INC    (BASE_INC),
      .SAMPLE_DIV  (SAMPLE_DIV),
      .MAX_CREDITS (MAX_CREDITS)
   ) u_dds_scope_top (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event       (key_event),
      .fsk_en          (fsk_en),
      .fsk_bit         (fsk_bit),
      .fsk_inc         (fsk_inc),
      .credit_return   (credit_return),
      .held_keys       (held_keys),
      .wave_sel        (wave_sel),
      .sample_valid    (sample_valid),
      .sample_out      (sample_out)
   );

   //////////////////////////////////////////////////
   // reporting and reference model
   //////////////////////////////////////////////////

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_held(input dds_scope_pkg::held_keys_t exp,
                             input dds_scope_pkg::held_keys_t act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] held_keys expected 0x%03h got 0x%03h", exp, act));
   endtask

   task automatic check_sel(input dds_scope_pkg::wave_sel_e exp,
                            input dds_scope_pkg::wave_sel_e act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] wave_sel expected 0x%01h got 0x%01h", exp, act));
   endtask

   task automatic check_sample(input dds_scope_pkg::sample_t exp,
                               input dds_scope_pkg::sample_t act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] sample_out expected 0x%012h got 0x%012h", exp, act));
   endtask

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return (lcg_state >> 16) & 32'h7FFF;
   endfunction

   // waveform as the shaping rules define it
   function automatic logic [WW-1:0] expected_wave(input logic [PW-1:0] ph,
                                                   input dds_scope_pkg::wave_sel_e sel);
      logic [WW-1:0] t;
      logic [WW-1:0] top;
      t   = ph[PW-2 -: WW];
      top = 1 << (WW - 1);
      case (sel)
         dds_scope_pkg::WAVE_SQUARE:   return ph[PW-1] ? top : ~top;
         dds_scope_pkg::WAVE_TRIANGLE: return (ph[PW-1] ? ~t : t) ^ top;
         default:                      return ph[PW-1 -: WW] ^ top;
      endcase
   endfunction

   function automatic int highest_digit(input logic [7:0] digits);
      int step;
      step = 0;
      for (int i = 0; i < 8; i++)
         if (digits[i])
            step = i + 1;
      return step;
   endfunction

   //////////////////////////////////////////////////
   // stream monitor, runs all the time
   //////////////////////////////////////////////////

   always @(negedge CLK_25MHZ)
   begin
      if (!reset_from_key)
      begin
         cycle++;
         if (sample_valid)
         begin
            if (cycle - last_emit < 2)
               abort_run("sample_valid pulses came on back-to-back cycles");
            if (cycle - prev_emit <= SAMPLE_DIV)   // only one catch-up allowed
               abort_run("more than one sample emitted inside one divider period");
            prev_emit = last_emit;
            last_emit = cycle;
            seen++;
            if (seen - given > MAX_CREDITS)
               abort_run("more samples outstanding than the stream has credits");
         end
      end
   end

   //////////////////////////////////////////////////
   // stimulus commands
   //////////////////////////////////////////////////

   task automatic send_key(input logic [7:0] code, input logic [8:0] held,
                           input logic [1:0] sel);
      @(posedge CLK_25MHZ);
      key_event_valid <= 1'b1;
      key_event       <= dds_scope_pkg::key_event_e'(code);
      @(posedge CLK_25MHZ);
      key_event_valid <= 1'b0;
      @(negedge CLK_25MHZ);
      held_exp = dds_scope_pkg::held_keys_t'(held);
      sel_exp  = dds_scope_pkg::wave_sel_e'(sel);
      check_held(held_exp, held_keys);
      check_sel(sel_exp, wave_sel);
      repeat (2) @(posedge CLK_25MHZ);   // dds picks up the new step
   endtask

   task automatic set_fsk(input logic en, input logic fbit, input logic [PW-1:0] inc);
      @(posedge CLK_25MHZ);
      fsk_en  <= en;
      fsk_bit <= fbit;
      fsk_inc <= inc;
      repeat (2) @(posedge CLK_25MHZ);
   endtask

   // mode 0 returns at once, 1 after random delays, 2 withholds first
   task automatic consume(input int count, input int mode);
      dds_scope_pkg::sample_t prev;
      dds_scope_pkg::sample_t cur;
      dds_scope_pkg::sample_t exp;
      logic [PW-1:0]          inc;
      int                     got;
      int                     waited;
      int                     prev_at;
      int                     hold_left;
      int                     stall;
      bit                     withhold;
      bit                     have_prev;
      got       = 0;
      waited    = 0;
      prev_at   = 0;
      hold_left = 0;
      stall     = 0;
      have_prev = 1'b0;
      withhold  = (mode == 2);
      inc = (fsk_en && fsk_bit) ? fsk_inc : PW'(highest_digit(held_exp.digits)) * BASE_INC;
      while (got < count)
      begin
         @(posedge CLK_25MHZ);
         waited++;
         if (waited > count * SAMPLE_DIV * 8 + 400)
            abort_run($sformatf("timed out waiting for sample %0d of %0d", got + 1, count));
         if (withhold)
         begin
            credit_return <= 1'b0;
            if (seen - given >= MAX_CREDITS)
               stall++;
            if (stall >= 3 * SAMPLE_DIV)   // stream starved long enough
               withhold = 1'b0;
         end
         else if (seen - given > 0 && hold_left == 0)
         begin
            credit_return <= 1'b1;
            given++;
            if (mode == 1)
               hold_left = lcg_next() % 8;
         end
         else
         begin
            credit_return <= 1'b0;
            if (hold_left > 0)
               hold_left--;
         end
         @(negedge CLK_25MHZ);
         if (sample_valid)
         begin
            cur = sample_out;
            exp = '{phase: cur.phase, wave: expected_wave(cur.phase, sel_exp), sel: sel_exp};
            if (have_prev)   // one step added per cycle since the last sample
               exp.phase = prev.phase + PW'(waited - prev_at) * inc;
            check_sample(exp, cur);
            prev      = cur;
            prev_at   = waited;
            have_prev = 1'b1;
            got++;
         end
      end
      @(posedge CLK_25MHZ);
      credit_return <= 1'b0;
   endtask

   // space is held here, so the divider must stay frozen
   task automatic pause_window(input int cycles);
      int waited;
      int hits;
      waited = 0;
      hits   = 0;
      while (seen - given > 0)
      begin
         @(posedge CLK_25MHZ);
         waited++;
         if (waited > 200)
            abort_run("timed out handing credits back before the pause window");
         credit_return <= 1'b1;
         given++;
      end
      @(posedge CLK_25MHZ);
      credit_return <= 1'b0;
      for (int i = 0; i < cycles; i++)
      begin
         @(negedge CLK_25MHZ);
         if (sample_valid)
         begin
            if (i >= 4 || hits > 0)
               abort_run($sformatf("sample emitted %0d cycles into the pause window", i));
            hits++;
         end
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////

   initial
   begin
      int          fd;
      int          waited;
      int          n;
      int          cnt;
      int          mode;
      string       line;
      byte         cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] d;
      key_event_valid <= 1'b0;
      key_event       <= dds_scope_pkg::SC_MAKE_1;
      fsk_en          <= 1'b0;
      fsk_bit         <= 1'b0;
      fsk_inc         <= '0;
      credit_return   <= 1'b0;
      waited = 0;
      #1;
      while (reset_from_key)
      begin
         @(posedge CLK_25MHZ);
         waited++;
         if (waited > 100)
            abort_run("reset was never released");
      end
      fd = $fopen("testbench/dds_scope_stim.txt", "r");
      if (fd == 0)
         abort_run("could not open testbench/dds_scope_stim.txt");
      while ($fgets(line, fd) != 0)
      begin
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         cmd = line.getc(0);
         case (cmd)
            "K":
            begin
               n = $sscanf(line, "%c %h %h %h", cmd, a, b, d);
               if (n != 4)
                  abort_run($sformatf("malformed key line in stimulus file: %s", line));
               send_key(a[7:0], b[8:0], d[1:0]);
            end
            "F":
            begin
               n = $sscanf(line, "%c %h %h %h", cmd, a, b, d);
               if (n != 4)
                  abort_run($sformatf("malformed fsk line in stimulus file: %s", line));
               set_fsk(a[0], b[0], d);
            end
            "C":
            begin
               n = $sscanf(line, "%c %d %d", cmd, cnt, mode);
               if (n != 3)
                  abort_run($sformatf("malformed consume line in stimulus file: %s", line));
               consume(cnt, mode);
            end
            "P":
            begin
               n = $sscanf(line, "%c %d", cmd, cnt);
               if (n != 2)
                  abort_run($sformatf("malformed pause line in stimulus file: %s", line));
               pause_window(cnt);
            end
            default:
               abort_run($sformatf("unknown command in stimulus file: %s", line));
         endcase
      end
      $fclose(fd);
      $display("all tests passed");
      $finish;
   end

endmodule
